/* project.f */
+incdir+common
+incdir+dv
common/tdt_csr_pkg.sv
common/tdt_halt_pkg.sv
trigger_csr/tdt_csr_regs.sv
halt_ctrl/tdt_retire_decode.sv
halt_ctrl/tdt_halt_record.sv
src/tdt_debug_top.sv
dv/tdt_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := tdt_tb
FILELIST := project.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := No errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

# pass only if the pass line shows up in the log
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* dv/tdt_tb_tasks.svh */
// ====================
// compare tasks, reference rules and directed tests
// included inside tdt_tb, uses its signals and counters
// every check runs 2 ns after the falling edge
// ====================

  // ====================
  // stimulus helpers
  // ====================
  task automatic tick();
    @(negedge m_iie_clk);
  endtask

  // let combinational outputs follow new inputs
  task automatic settle();
    #2;
  endtask

  task automatic idle_inputs();
    cp0_dtu_wdata            = '0;
    cp0_write_tselect        = 1'b0;
    cp0_write_tcontrol       = 1'b0;
    cp0_write_mcontext       = 1'b0;
    cp0_dtu_mexpt_vld        = 1'b0;
    rtu_dtu_retire_mret      = 1'b0;
    rtu_dtu_retire_vld       = 1'b0;
    rtu_dtu_retire_halt_info = '0;
    rtu_dtu_halt_ack         = 1'b0;
    rtu_dtu_pending_ack      = 1'b0;
    rtu_yy_xx_dbgon          = 1'b0;
    mcontrol_action0         = '0;
    mcontrol_action1         = '0;
    mcontrol_halt_info0      = '0;
    mcontrol_halt_info1      = '0;
  endtask

  // one-cycle csr write, returns after the write edge
  task automatic write_csr(input int which, input csr_data_t data);
    tick();
    cp0_dtu_wdata      = data;
    cp0_write_tselect  = (which == SEL_TSELECT);
    cp0_write_tcontrol = (which == SEL_TCONTROL);
    cp0_write_mcontext = (which == SEL_MCONTEXT);
    tick();
    cp0_write_tselect  = 1'b0;
    cp0_write_tcontrol = 1'b0;
    cp0_write_mcontext = 1'b0;
    settle();
  endtask

  task automatic pulse_trap_mret(input logic trap, input logic mret, input logic retired);
    tick();
    cp0_dtu_mexpt_vld   = trap;
    rtu_dtu_retire_mret = mret;
    rtu_dtu_retire_vld  = retired;
    tick();
    cp0_dtu_mexpt_vld   = 1'b0;
    rtu_dtu_retire_mret = 1'b0;
    rtu_dtu_retire_vld  = 1'b0;
    settle();
  endtask

  task automatic drive_retire(input hinfo_t word, input logic vld, input logic ack,
                              input trig_vec_t a0, input trig_vec_t a1);
    tick();
    rtu_dtu_retire_halt_info = word;
    rtu_dtu_retire_vld       = vld;
    rtu_dtu_halt_ack         = ack;
    mcontrol_action0         = a0;
    mcontrol_action1         = a1;
  endtask

  // call right after a tick
  task automatic clear_retire();
    rtu_dtu_retire_halt_info = '0;
    rtu_dtu_retire_vld       = 1'b0;
    rtu_dtu_halt_ack         = 1'b0;
  endtask

  // ====================
  // compare tasks
  // ====================
  task automatic check_csr(input csr_data_t got, input csr_data_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_hinfo(input hinfo_t got, input hinfo_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_trig(input trig_vec_t got, input trig_vec_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_cause(input cause_t got, input cause_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // both fetch words plus the in-use flag
  task automatic check_fetch(input hinfo_t exp0, input hinfo_t exp1, input logic exp_vld,
                             input string what);
    check_hinfo(dtu_ifu_halt_info0, exp0, {what, " info0"});
    check_hinfo(dtu_ifu_halt_info1, exp1, {what, " info1"});
    check_bit(dtu_ifu_halt_info_vld, exp_vld, {what, " info_vld"});
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before)
      $display("test %s: PASS", name);
    else
    begin
      failed_tests++;
      $display("test %s: FAIL with %0d errors", name, error_count - errors_before);
    end
  endtask

  // ====================
  // reference rules
  // ====================
  function automatic csr_data_t clamp_tselect(input csr_data_t data);
    if (data > csr_data_t'(`TDT_TSELECT_MAX))
      return csr_data_t'(`TDT_TSELECT_MAX);
    return data;
  endfunction

  function automatic csr_data_t tcontrol_value(input logic mte, input logic mpte);
    csr_data_t value;
    value                = '0;
    value[`TDT_MTE_BIT]  = mte;
    value[`TDT_MPTE_BIT] = mpte;
    return value;
  endfunction

  // hits on a qualified word
  function automatic trig_vec_t expected_hit(input hinfo_t q, input logic ack,
                                             input trig_vec_t a0);
    logic      timing0;
    trig_vec_t field;
    field   = q[`TDT_HINFO_TRIGGER -: `TDT_TRIG_NUM];
    timing0 = ack || (q[`TDT_HINFO_MATCH] && !q[`TDT_HINFO_CHAIN] && !q[`TDT_HINFO_TIMING]);
    if (!timing0)
      return '0;
    if (q[`TDT_HINFO_ACTION01])
      return field & a0;
    return field;
  endfunction

  function automatic logic expected_tval(input hinfo_t q);
    return q[`TDT_HINFO_MATCH] && !q[`TDT_HINFO_CHAIN] &&
           q[`TDT_HINFO_TIMING] && !q[`TDT_HINFO_ACTION];
  endfunction

  // record word as seen by fetch, dbgon low
  function automatic hinfo_t record_info(input trig_vec_t hit, input cause_t cause,
                                         input logic act01, input logic act, input logic ldst);
    hinfo_t w;
    w = '0;
    w[`TDT_HINFO_TRIGGER -: `TDT_TRIG_NUM] = hit;
    w[`TDT_HINFO_CAUSE -: $bits(cause_t)]  = cause;
    w[`TDT_HINFO_PENDING_HALT]             = 1'b1;
    w[`TDT_HINFO_ACTION01]                 = act01;
    w[`TDT_HINFO_ACTION]                   = act;
    w[`TDT_HINFO_LDST]                     = ldst;
    w[`TDT_HINFO_MATCH]                    = |hit;
    w[`TDT_HINFO_CANCEL]                   = 1'b1;
    return w;
  endfunction

  // ====================
  // directed tests
  // ====================
  task automatic reset_csr_test();
    int        errors_before;
    csr_data_t wdata;
    errors_before = error_count;
    settle();
    check_csr(tselect, '0, "tselect after reset");
    check_csr(tcontrol, '0, "tcontrol after reset");
    check_csr(mcontext, '0, "mcontext after reset");
    check_bit(pending_halt, 1'b0, "pending_halt after reset");
    check_bit(dtu_ifu_halt_info_vld, 1'b0, "info_vld after reset");
    for (int i = 0; i < 8; i++)
    begin
      // small values on even passes so both clamp paths show up
      if (i % 2 == 0)
        wdata = csr_data_t'($urandom % 8);
      else
        wdata = csr_data_t'($urandom);
      write_csr(SEL_TSELECT, wdata);
      check_csr(tselect, clamp_tselect(wdata), "tselect readback");
    end
    for (int i = 0; i < 4; i++)
    begin
      wdata = csr_data_t'($urandom);
      write_csr(SEL_MCONTEXT, wdata);
      check_csr(mcontext, wdata & csr_data_t'((1 << `TDT_MCONTEXT_BITS) - 1),
                "mcontext readback");
    end
    for (int i = 0; i < 4; i++)
    begin
      wdata = csr_data_t'($urandom);
      write_csr(SEL_TCONTROL, wdata);
      check_csr(tcontrol, tcontrol_value(wdata[`TDT_MTE_BIT], wdata[`TDT_MPTE_BIT]),
                "tcontrol readback");
    end
    report_test("reset_csr", errors_before);
  endtask

  task automatic trap_mret_test();
    int errors_before;
    errors_before = error_count;
    write_csr(SEL_TCONTROL, tcontrol_value(1'b1, 1'b0));
    check_csr(tcontrol, tcontrol_value(1'b1, 1'b0), "tcontrol with mte set");
    // trap saves mte into mpte
    pulse_trap_mret(1'b1, 1'b0, 1'b0);
    check_csr(tcontrol, tcontrol_value(1'b0, 1'b1), "tcontrol after trap");
    pulse_trap_mret(1'b0, 1'b1, 1'b1);
    check_csr(tcontrol, tcontrol_value(1'b1, 1'b1), "tcontrol after mret");
    // mret that does not retire
    pulse_trap_mret(1'b0, 1'b1, 1'b0);
    check_csr(tcontrol, tcontrol_value(1'b1, 1'b1), "tcontrol after unretired mret");
    pulse_trap_mret(1'b1, 1'b1, 1'b1);
    check_csr(tcontrol, tcontrol_value(1'b0, 1'b1), "tcontrol after trap with mret");
    // same again with mpte clear
    write_csr(SEL_TCONTROL, tcontrol_value(1'b1, 1'b0));
    pulse_trap_mret(1'b1, 1'b1, 1'b1);
    check_csr(tcontrol, tcontrol_value(1'b0, 1'b0), "tcontrol trap with mret, mpte 0");
    report_test("trap_mret", errors_before);
  endtask

  task automatic retire_decode_test();
    int        errors_before;
    hinfo_t    word;
    logic      vld;
    logic      ack;
    trig_vec_t a0;
    errors_before = error_count;
    for (int i = 0; i < DECODE_WORDS; i++)
    begin
      word = hinfo_t'($urandom);
      a0   = trig_vec_t'($urandom);
      // retire only, ack only, then both
      vld  = (i % 3 != 1);
      ack  = (i % 3 != 0);
      // retire-only words carry a plain match, before and after retire
      if (!ack)
      begin
        word[`TDT_HINFO_MATCH]  = 1'b1;
        word[`TDT_HINFO_CHAIN]  = 1'b0;
        word[`TDT_HINFO_TIMING] = i[0];
        word[`TDT_HINFO_ACTION] = (i >= 6);
      end
      drive_retire(word, vld, ack, a0, '0);
      settle();
      check_trig(mcontrol_hit, expected_hit(word, ack, a0), "qualified mcontrol_hit");
      check_cause(dtu_cause, word[`TDT_HINFO_CAUSE -: $bits(cause_t)], "qualified dtu_cause");
      check_bit(updata_tval, expected_tval(word), "qualified updata_tval");
      // same word without qualifier
      drive_retire(word, 1'b0, 1'b0, a0, '0);
      settle();
      check_trig(mcontrol_hit, '0, "unqualified mcontrol_hit");
      check_cause(dtu_cause, '0, "unqualified dtu_cause");
      check_bit(updata_tval, 1'b0, "unqualified updata_tval");
    end
    // drop any flag the random words raised
    tick();
    idle_inputs();
    rtu_dtu_pending_ack = 1'b1;
    rtu_yy_xx_dbgon     = 1'b1;
    tick();
    idle_inputs();
    settle();
    check_bit(pending_halt, 1'b0, "pending_halt after cleanup");
    check_bit(dtu_ifu_halt_info_vld, 1'b0, "info_vld after cleanup");
    report_test("retire_decode", errors_before);
  endtask

  task automatic pending_halt_test();
    int     errors_before;
    hinfo_t word;
    hinfo_t pass0;
    hinfo_t pass1;
    hinfo_t expected;
    errors_before = error_count;
    pass0 = hinfo_t'($urandom);
    pass1 = hinfo_t'($urandom);
    word  = hinfo_t'($urandom);
    word[`TDT_HINFO_PENDING_HALT] = 1'b1;
    // keep the action01 flag out of this test
    word[`TDT_HINFO_ACTION01] = 1'b0;
    expected = record_info(word[`TDT_HINFO_TRIGGER -: `TDT_TRIG_NUM],
                           word[`TDT_HINFO_CAUSE -: $bits(cause_t)], 1'b0,
                           word[`TDT_HINFO_ACTION], word[`TDT_HINFO_LDST]);
    tick();
    mcontrol_halt_info0 = pass0;
    mcontrol_halt_info1 = pass1;
    settle();
    check_fetch(pass0, pass1, 1'b0, "before pending halt");
    drive_retire(word, 1'b1, 1'b0, '0, '0);
    tick();
    clear_retire();
    settle();
    check_bit(pending_halt, 1'b1, "pending_halt set");
    check_fetch(expected, expected, 1'b1, "pending record");
    tick();
    settle();
    check_fetch(expected, expected, 1'b1, "pending record held");
    // dbgon blanks the record word at once
    tick();
    rtu_yy_xx_dbgon = 1'b1;
    settle();
    check_fetch('0, '0, 1'b1, "pending record under dbgon");
    tick();
    rtu_yy_xx_dbgon     = 1'b0;
    rtu_dtu_pending_ack = 1'b1;
    settle();
    check_fetch(expected, expected, 1'b1, "pending ack cycle");
    tick();
    rtu_dtu_pending_ack = 1'b0;
    settle();
    check_bit(pending_halt, 1'b0, "pending_halt after ack");
    check_fetch(pass0, pass1, 1'b0, "after pending ack");
    report_test("pending_halt", errors_before);
  endtask

  task automatic action01_test();
    int        errors_before;
    hinfo_t    word;
    hinfo_t    pass0;
    hinfo_t    pass1;
    hinfo_t    expected;
    trig_vec_t a0;
    trig_vec_t a1;
    trig_vec_t field;
    errors_before = error_count;
    pass0 = hinfo_t'($urandom);
    pass1 = hinfo_t'($urandom);
    a0    = trig_vec_t'($urandom);
    a1    = trig_vec_t'($urandom);
    word  = hinfo_t'($urandom);
    // before-retire match with action01, no pending halt
    word[`TDT_HINFO_MATCH]        = 1'b1;
    word[`TDT_HINFO_CHAIN]        = 1'b0;
    word[`TDT_HINFO_TIMING]       = 1'b0;
    word[`TDT_HINFO_ACTION01]     = 1'b1;
    word[`TDT_HINFO_PENDING_HALT] = 1'b0;
    field    = word[`TDT_HINFO_TRIGGER -: `TDT_TRIG_NUM];
    expected = record_info(field & a1, word[`TDT_HINFO_CAUSE -: $bits(cause_t)], 1'b0,
                           1'b1, word[`TDT_HINFO_LDST]);
    tick();
    mcontrol_halt_info0 = pass0;
    mcontrol_halt_info1 = pass1;
    drive_retire(word, 1'b1, 1'b0, a0, a1);
    settle();
    check_trig(mcontrol_hit, field & a0, "action01 mcontrol_hit");
    tick();
    clear_retire();
    settle();
    check_bit(pending_halt, 1'b0, "pending_halt with action01");
    check_fetch(expected, expected, 1'b1, "action01 record");
    // entering debug releases the fetch words at once
    tick();
    rtu_yy_xx_dbgon = 1'b1;
    settle();
    check_fetch(pass0, pass1, 1'b0, "action01 under dbgon");
    // one edge with dbgon high drops the flag for good
    tick();
    rtu_yy_xx_dbgon = 1'b0;
    settle();
    check_fetch(pass0, pass1, 1'b0, "action01 flag cleared");
    report_test("action01", errors_before);
  endtask

/* dv/tdt_tb.sv */
// ====================
// testbench for the trigger-control core
// directed tests only, inputs change on the falling edge
// watchdog bound comes from the per-test cycle budgets below
// ====================
`timescale 1ns/1ns
`include "tdt_settings.svh"

module tdt_tb
  import tdt_csr_pkg::*;
  import tdt_halt_pkg::*;
();

  // ====================
  // run length
  // ====================
  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 4;
  // rough cycle budget of each test
  localparam int CSR_CYCLES      = 36;
  localparam int TRAP_CYCLES     = 16;
  localparam int DECODE_CYCLES   = 30;
  localparam int PENDING_CYCLES  = 12;
  localparam int ACTION01_CYCLES = 10;
  localparam int MARGIN_CYCLES   = 40;
  localparam int WATCHDOG_NS     = CLK_PERIOD * (RESET_CYCLES + CSR_CYCLES + TRAP_CYCLES +
                                                 DECODE_CYCLES + PENDING_CYCLES +
                                                 ACTION01_CYCLES + MARGIN_CYCLES);

  localparam int unsigned SEED = 32'h25590ff5;

  // csr write select codes
  localparam int SEL_TSELECT  = 0;
  localparam int SEL_TCONTROL = 1;
  localparam int SEL_MCONTEXT = 2;

  // words per decode run
  localparam int DECODE_WORDS = 12;

  // ====================
  // dut signals
  // ====================
  logic      m_iie_clk;
  logic      cpurst_b;
  csr_data_t cp0_dtu_wdata;
  logic      cp0_write_tselect;
  logic      cp0_write_tcontrol;
  logic      cp0_write_mcontext;
  logic      cp0_dtu_mexpt_vld;
  logic      rtu_dtu_retire_mret;
  logic      rtu_dtu_retire_vld;
  hinfo_t    rtu_dtu_retire_halt_info;
  logic      rtu_dtu_halt_ack;
  logic      rtu_dtu_pending_ack;
  logic      rtu_yy_xx_dbgon;
  trig_vec_t mcontrol_action0;
  trig_vec_t mcontrol_action1;
  hinfo_t    mcontrol_halt_info0;
  hinfo_t    mcontrol_halt_info1;

  csr_data_t tselect;
  csr_data_t tcontrol;
  csr_data_t mcontext;
  trig_vec_t mcontrol_hit;
  cause_t    dtu_cause;
  logic      updata_tval;
  logic      pending_halt;
  hinfo_t    dtu_ifu_halt_info0;
  hinfo_t    dtu_ifu_halt_info1;
  logic      dtu_ifu_halt_info_vld;

  // result counters
  int error_count;
  int check_count;
  int test_count;
  int failed_tests;

  tdt_debug_top u_tdt_debug_top (.*);

  `include "tdt_tb_tasks.svh"

  // free running clock
  always #(CLK_PERIOD / 2) m_iie_clk = ~m_iie_clk;

  // ====================
  // watchdog
  // ====================
  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: test sequence still running after %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

  // ====================
  // test sequence
  // ====================
  initial
  begin
    error_count  = 0;
    check_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    m_iie_clk    = 1'b0;
    cpurst_b     = 1'b1;
    idle_inputs();
    void'($urandom(SEED));

    // async reset, held low for four cycles
    #1;
    cpurst_b = 1'b0;
    repeat (RESET_CYCLES) @(posedge m_iie_clk);
    @(negedge m_iie_clk);
    cpurst_b = 1'b1;

    reset_csr_test();
    trap_mret_test();
    retire_decode_test();
    pending_halt_test();
    action01_test();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

/* src/tdt_debug_top.sv */
// ====================
// trigger-control core top, wiring only
// match block results come in as masks and fetch halt-info words
// ====================
`timescale 1ns/1ns

module tdt_debug_top
  import tdt_csr_pkg::*;
  import tdt_halt_pkg::*;
(
  input  logic      m_iie_clk,
  input  logic      cpurst_b,
  // csr access
  input  csr_data_t cp0_dtu_wdata,
  input  logic      cp0_write_tselect,
  input  logic      cp0_write_tcontrol,
  input  logic      cp0_write_mcontext,
  input  logic      cp0_dtu_mexpt_vld,
  // retire side
  input  logic      rtu_dtu_retire_mret,
  input  logic      rtu_dtu_retire_vld,
  input  hinfo_t    rtu_dtu_retire_halt_info,
  input  logic      rtu_dtu_halt_ack,
  input  logic      rtu_dtu_pending_ack,
  input  logic      rtu_yy_xx_dbgon,
  // match block results
  input  trig_vec_t mcontrol_action0,
  input  trig_vec_t mcontrol_action1,
  input  hinfo_t    mcontrol_halt_info0,
  input  hinfo_t    mcontrol_halt_info1,
  // outputs
  output csr_data_t tselect,
  output csr_data_t tcontrol,
  output csr_data_t mcontext,
  output trig_vec_t mcontrol_hit,
  output cause_t    dtu_cause,
  output logic      updata_tval,
  output logic      pending_halt,
  output hinfo_t    dtu_ifu_halt_info0,
  output hinfo_t    dtu_ifu_halt_info1,
  output logic      dtu_ifu_halt_info_vld
);

  // decode to record
  logic      generate_pending_halt;
  logic      generate_retire_action01;
  trig_vec_t record_hit;
  logic      record_action;
  logic      record_action01;
  logic      record_ldst;

  tdt_csr_regs u_csr_regs (
    .m_iie_clk           (m_iie_clk),
    .cpurst_b            (cpurst_b),
    .cp0_dtu_wdata       (cp0_dtu_wdata),
    .cp0_write_tselect   (cp0_write_tselect),
    .cp0_write_tcontrol  (cp0_write_tcontrol),
    .cp0_write_mcontext  (cp0_write_mcontext),
    .cp0_dtu_mexpt_vld   (cp0_dtu_mexpt_vld),
    .rtu_dtu_retire_mret (rtu_dtu_retire_mret),
    .rtu_dtu_retire_vld  (rtu_dtu_retire_vld),
    .tselect             (tselect),
    .tcontrol            (tcontrol),
    .mcontext            (mcontext)
  );

  tdt_retire_decode u_retire_decode (
    .rtu_dtu_retire_halt_info (rtu_dtu_retire_halt_info),
    .rtu_dtu_retire_vld       (rtu_dtu_retire_vld),
    .rtu_dtu_halt_ack         (rtu_dtu_halt_ack),
    .mcontrol_action0         (mcontrol_action0),
    .mcontrol_action1         (mcontrol_action1),
    .mcontrol_hit             (mcontrol_hit),
    .dtu_cause                (dtu_cause),
    .updata_tval              (updata_tval),
    .generate_pending_halt    (generate_pending_halt),
    .generate_retire_action01 (generate_retire_action01),
    .record_hit               (record_hit),
    .record_action            (record_action),
    .record_action01          (record_action01),
    .record_ldst              (record_ldst)
  );

  tdt_halt_record u_halt_record (
    .m_iie_clk                (m_iie_clk),
    .cpurst_b                 (cpurst_b),
    .generate_pending_halt    (generate_pending_halt),
    .generate_retire_action01 (generate_retire_action01),
    .record_hit               (record_hit),
    .record_action            (record_action),
    .record_action01          (record_action01),
    .record_ldst              (record_ldst),
    .dtu_cause                (dtu_cause),
    .rtu_dtu_pending_ack      (rtu_dtu_pending_ack),
    .rtu_yy_xx_dbgon          (rtu_yy_xx_dbgon),
    .mcontrol_halt_info0      (mcontrol_halt_info0),
    .mcontrol_halt_info1      (mcontrol_halt_info1),
    .pending_halt             (pending_halt),
    .dtu_ifu_halt_info0       (dtu_ifu_halt_info0),
    .dtu_ifu_halt_info1       (dtu_ifu_halt_info1),
    .dtu_ifu_halt_info_vld    (dtu_ifu_halt_info_vld)
  );

endmodule

/* halt_ctrl/tdt_halt_record.sv */
// ====================
// pending-halt and action01 flags with their record register
// record replaces both fetch halt-info words while in use
// record info reads as zero while dbgon is high
// ====================
`timescale 1ns/1ns
`include "tdt_settings.svh"

module tdt_halt_record
  import tdt_halt_pkg::*;
(
  input  logic      m_iie_clk,
  input  logic      cpurst_b,
  input  logic      generate_pending_halt,
  input  logic      generate_retire_action01,
  input  trig_vec_t record_hit,
  input  logic      record_action,
  input  logic      record_action01,
  input  logic      record_ldst,
  input  cause_t    dtu_cause,
  input  logic      rtu_dtu_pending_ack,
  input  logic      rtu_yy_xx_dbgon,
  input  hinfo_t    mcontrol_halt_info0,
  input  hinfo_t    mcontrol_halt_info1,
  output logic      pending_halt,
  output hinfo_t    dtu_ifu_halt_info0,
  output hinfo_t    dtu_ifu_halt_info1,
  output logic      dtu_ifu_halt_info_vld
);

  logic      retire_action01;
  logic      clear_action01;
  logic      clear_record;
  trig_vec_t record_hit_q;
  logic      record_action_q;
  logic      record_action01_q;
  logic      record_ldst_q;
  cause_t    record_cause_q;
  hinfo_t    record_halt_info;

  // ====================
  // flags
  // ====================
  always_ff @(posedge m_iie_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pending_halt <= 1'b0;
    else if (generate_pending_halt)
      pending_halt <= 1'b1;
    else if (rtu_dtu_pending_ack)
      pending_halt <= 1'b0;
  end

  // action01 drops once debug mode is entered
  assign clear_action01 = retire_action01 && rtu_yy_xx_dbgon;

  always_ff @(posedge m_iie_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      retire_action01 <= 1'b0;
    else if (generate_retire_action01)
      retire_action01 <= 1'b1;
    else if (clear_action01)
      retire_action01 <= 1'b0;
  end

  // ====================
  // record register
  // ====================
  assign clear_record = (pending_halt && rtu_dtu_pending_ack) || clear_action01;

  // a new record wins over a clear
  always_ff @(posedge m_iie_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      record_hit_q      <= '0;
      record_action_q   <= 1'b0;
      record_action01_q <= 1'b0;
      record_ldst_q     <= 1'b0;
      record_cause_q    <= '0;
    end
    else if (generate_pending_halt || generate_retire_action01)
    begin
      record_hit_q      <= record_hit;
      record_action_q   <= record_action;
      record_action01_q <= record_action01;
      record_ldst_q     <= record_ldst;
      record_cause_q    <= dtu_cause;
    end
    else if (clear_record)
    begin
      record_hit_q      <= '0;
      record_action_q   <= 1'b0;
      record_action01_q <= 1'b0;
      record_ldst_q     <= 1'b0;
      record_cause_q    <= '0;
    end
  end

  // ====================
  // record halt info
  // ====================
  // timing and chain always zero, cancel always set
  always_comb
  begin
    record_halt_info = '0;
    if (!rtu_yy_xx_dbgon)
    begin
      record_halt_info[`TDT_HINFO_TRIGGER -: `TDT_TRIG_NUM] = record_hit_q;
      record_halt_info[`TDT_HINFO_CAUSE -: $bits(cause_t)]  = record_cause_q;
      record_halt_info[`TDT_HINFO_PENDING_HALT] = pending_halt || retire_action01;
      record_halt_info[`TDT_HINFO_ACTION01]     = record_action01_q;
      record_halt_info[`TDT_HINFO_ACTION]       = record_action_q;
      record_halt_info[`TDT_HINFO_LDST]         = record_ldst_q;
      record_halt_info[`TDT_HINFO_MATCH]        = |record_hit_q;
      record_halt_info[`TDT_HINFO_CANCEL]       = 1'b1;
    end
  end

  // fetch side select
  assign dtu_ifu_halt_info_vld = pending_halt || (retire_action01 && !rtu_yy_xx_dbgon);

  assign dtu_ifu_halt_info0 = dtu_ifu_halt_info_vld ? record_halt_info : mcontrol_halt_info0;
  assign dtu_ifu_halt_info1 = dtu_ifu_halt_info_vld ? record_halt_info : mcontrol_halt_info1;

endmodule

/* halt_ctrl/tdt_retire_decode.sv */
// ====================
// decodes the halt-info word returned at retire
// word counts only with retire_vld or halt_ack, else seen as zero
// all outputs combinational in the same cycle
// ====================
`timescale 1ns/1ns
`include "tdt_settings.svh"

module tdt_retire_decode
  import tdt_halt_pkg::*;
(
  input  hinfo_t    rtu_dtu_retire_halt_info,
  input  logic      rtu_dtu_retire_vld,
  input  logic      rtu_dtu_halt_ack,
  input  trig_vec_t mcontrol_action0,
  input  trig_vec_t mcontrol_action1,
  output trig_vec_t mcontrol_hit,
  output cause_t    dtu_cause,
  output logic      updata_tval,
  output logic      generate_pending_halt,
  output logic      generate_retire_action01,
  output trig_vec_t record_hit,
  output logic      record_action,
  output logic      record_action01,
  output logic      record_ldst
);

  hinfo_t    rtu_info;
  trig_vec_t triggers_match;
  logic      timing0;

  // qualified word
  assign rtu_info = (rtu_dtu_retire_vld || rtu_dtu_halt_ack) ? rtu_dtu_retire_halt_info : '0;

  assign triggers_match = rtu_info[`TDT_HINFO_TRIGGER -: `TDT_TRIG_NUM];
  assign dtu_cause      = rtu_info[`TDT_HINFO_CAUSE -: $bits(cause_t)];

  // halt ack, or a before-retire match outside a chain
  assign timing0 = rtu_dtu_halt_ack ||
                   (rtu_info[`TDT_HINFO_MATCH] && !rtu_info[`TDT_HINFO_CHAIN] &&
                    !rtu_info[`TDT_HINFO_TIMING]);

  // after-retire match with no action needs a tval update
  assign updata_tval = rtu_info[`TDT_HINFO_MATCH] && !rtu_info[`TDT_HINFO_CHAIN] &&
                       rtu_info[`TDT_HINFO_TIMING] && !rtu_info[`TDT_HINFO_ACTION];

  // ====================
  // trigger hit
  // ====================
  always_comb
  begin
    if (!timing0)
      mcontrol_hit = '0;
    else if (rtu_info[`TDT_HINFO_ACTION01])
      mcontrol_hit = triggers_match & mcontrol_action0;
    else
      mcontrol_hit = triggers_match;
  end

  // ====================
  // record sources
  // ====================
  assign generate_pending_halt    = rtu_info[`TDT_HINFO_PENDING_HALT];
  assign generate_retire_action01 = timing0 && rtu_info[`TDT_HINFO_ACTION01];

  // pending halt keeps the word as is
  // action01 case records the action1 triggers as a plain debug action
  assign record_hit      = generate_pending_halt ? triggers_match
                                                 : (triggers_match & mcontrol_action1);
  assign record_action   = generate_pending_halt ? rtu_info[`TDT_HINFO_ACTION] : 1'b1;
  assign record_action01 = generate_pending_halt && rtu_info[`TDT_HINFO_ACTION01];
  assign record_ldst     = rtu_info[`TDT_HINFO_LDST];

endmodule

/* trigger_csr/tdt_csr_regs.sv */
// ====================
// tselect, tcontrol and mcontext registers
// writes land on the next edge, readbacks zero-extended to xlen
// trap and mret take priority over a tcontrol write
// ====================
`timescale 1ns/1ns
`include "tdt_settings.svh"

module tdt_csr_regs
  import tdt_csr_pkg::*;
(
  input  logic      m_iie_clk,
  input  logic      cpurst_b,
  input  csr_data_t cp0_dtu_wdata,
  input  logic      cp0_write_tselect,
  input  logic      cp0_write_tcontrol,
  input  logic      cp0_write_mcontext,
  input  logic      cp0_dtu_mexpt_vld,
  input  logic      rtu_dtu_retire_mret,
  input  logic      rtu_dtu_retire_vld,
  output csr_data_t tselect,
  output csr_data_t tcontrol,
  output csr_data_t mcontext
);

  tselect_idx_t tselect_q;
  mcontext_t    mcontext_q;
  logic         mte_q;
  logic         mpte_q;
  logic         wdata_over_max;
  logic         mret_vld;

  // ====================
  // tselect
  // ====================
  // clamp to the highest trigger index
  assign wdata_over_max = (cp0_dtu_wdata[$bits(tselect_idx_t)-1:0] > `TDT_TSELECT_MAX) ||
                          (|cp0_dtu_wdata[`TDT_XLEN-1:$bits(tselect_idx_t)]);

  always_ff @(posedge m_iie_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      tselect_q <= '0;
    else if (cp0_write_tselect)
      tselect_q <= wdata_over_max ? tselect_idx_t'(`TDT_TSELECT_MAX)
                                  : cp0_dtu_wdata[$bits(tselect_idx_t)-1:0];
  end

  assign tselect = csr_data_t'(tselect_q);

  // ====================
  // tcontrol
  // ====================
  // only a retired mret counts
  assign mret_vld = rtu_dtu_retire_mret && rtu_dtu_retire_vld;

  always_ff @(posedge m_iie_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      mte_q  <= 1'b0;
      mpte_q <= 1'b0;
    end
    else if (cp0_dtu_mexpt_vld && mret_vld)
    begin
      // trap wins, mpte kept as is
      mte_q <= 1'b0;
    end
    else if (cp0_dtu_mexpt_vld)
    begin
      // trap into m mode saves mte
      mte_q  <= 1'b0;
      mpte_q <= mte_q;
    end
    else if (mret_vld)
      mte_q <= mpte_q;
    else if (cp0_write_tcontrol)
    begin
      mte_q  <= cp0_dtu_wdata[`TDT_MTE_BIT];
      mpte_q <= cp0_dtu_wdata[`TDT_MPTE_BIT];
    end
  end

  // readback, all other bits zero
  always_comb
  begin
    tcontrol                = '0;
    tcontrol[`TDT_MTE_BIT]  = mte_q;
    tcontrol[`TDT_MPTE_BIT] = mpte_q;
  end

  // ====================
  // mcontext
  // ====================
  always_ff @(posedge m_iie_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      mcontext_q <= '0;
    else if (cp0_write_mcontext)
      mcontext_q <= cp0_dtu_wdata[`TDT_MCONTEXT_BITS-1:0];
  end

  assign mcontext = csr_data_t'(mcontext_q);

endmodule

/* common/tdt_halt_pkg.sv */
// ====================
// halt-info and per-trigger vector types
// one bit per mcontrol trigger in trig_vec_t
// ====================
`include "tdt_settings.svh"

package tdt_halt_pkg;

  // halt-info word as exchanged with retire and fetch
  typedef logic [`TDT_HINFO_WIDTH-1:0] hinfo_t;

  // per-trigger vector
  // used for hits, action masks and trigger fields
  typedef logic [`TDT_TRIG_NUM-1:0] trig_vec_t;

  // halt cause field
  typedef logic [3:0] cause_t;

endpackage

/* common/tdt_csr_pkg.sv */
// ====================
// types for the trigger CSRs owned by the unit
// widths follow tdt_settings.svh
// ====================
`include "tdt_settings.svh"

package tdt_csr_pkg;

  // full csr write data and readback
  typedef logic [`TDT_XLEN-1:0] csr_data_t;

  // stored tselect index, clamped on write
  typedef logic [3:0] tselect_idx_t;

  // mcontext keeps only its low bits
  typedef logic [`TDT_MCONTEXT_BITS-1:0] mcontext_t;

endpackage

/* common/tdt_settings.svh */
// ====================
// trigger counts, CSR widths and halt-info field positions
// field macros give the top bit of each field in the halt-info word
// ====================
`ifndef TDT_SETTINGS_SVH
`define TDT_SETTINGS_SVH

// csr and trigger sizing
`define TDT_XLEN               32
`define TDT_TRIG_NUM           3
`define TDT_TSELECT_MAX        3
`define TDT_MCONTEXT_BITS      6

// tcontrol bit positions
`define TDT_MTE_BIT            3
`define TDT_MPTE_BIT           7

// ====================
// halt-info word layout
// ====================
`define TDT_HINFO_WIDTH        15
`define TDT_HINFO_TRIGGER      14
`define TDT_HINFO_CAUSE        11
`define TDT_HINFO_PENDING_HALT 7
`define TDT_HINFO_TIMING       6
`define TDT_HINFO_ACTION01     5
`define TDT_HINFO_ACTION       4
`define TDT_HINFO_CHAIN        3
`define TDT_HINFO_LDST         2
`define TDT_HINFO_MATCH        1
`define TDT_HINFO_CANCEL       0

`endif
